// ==== sim/mips_tests.txt ====
# test <name> | load <byte offset from TEXT_BASE> <word> | run | check <reg> <value>
# Offsets, words and values in hex, register numbers in decimal
test alu_ops
load 0000 2401fffb  # addiu $1, $0, -5
load 0004 3c021234  # lui   $2, 0x1234
load 0008 34428765  # ori   $2, $2, 0x8765
load 000c 00221821  # addu  $3, $1, $2
load 0010 00222023  # subu  $4, $1, $2
load 0014 00222824  # and   $5, $1, $2
load 0018 00223025  # or    $6, $1, $2
load 001c 0022382a  # slt   $7, $1, $2
load 0020 0000000d  # break
run
check 2 12348765
check 3 12348760
check 4 edcb7896
check 5 12348761
check 6 ffffffff
check 7 00000001
test load_store
load 0000 3c098012  # lui $9, 0x8012 is DATA_BASE
load 0004 ad210200  # sw  $1, 0x200($9)
load 0008 ad220204  # sw  $2, 0x204($9)
load 000c 8d2a0200  # lw  $10, 0x200($9)
load 0010 8d2b0204  # lw  $11, 0x204($9)
load 0014 0000000d
run
check 10 fffffffb
check 11 12348765
test branch_jump
load 0000 240e0001  # addiu $14, $0, 1
load 0004 11c00001  # beq $14, $0  not taken
load 0008 15c00001  # bne $14, $0  taken to 0x10
load 000c 24100022  # skipped marker
load 0010 11ce0001  # beq $14, $14 taken to 0x18
load 0014 24100033  # skipped marker
load 0018 15ce0001  # bne $14, $14 not taken
load 001c 08008009  # j 0x80020024
load 0020 24100055  # skipped marker
load 0024 240f0011  # addiu $15, $0, 0x11
load 0028 0000000d
run
check 15 00000011
check 16 00000000
test r0_rerun
load 0000 24000077  # addiu $0, $0, 0x77
load 0024 240f0066  # addiu $15, $0, 0x66
run
check 0 00000000
check 15 00000066

// ==== build.f ====
common/mips_pkg.sv
design/alu.sv
design/pc_counter.sv
design/register_file.sv
design/unified_memory.sv
design/stage_sequencer.sv
design/mips_core.sv
sim/clock_gen.sv
sim/mips_core_properties.sv
sim/mips_core_tb.sv

// ==== sim/mips_core_tb.sv ====
`timescale 1ns/1ps

module mips_core_tb;
	import mips_pkg::*;

	localparam int TIMEOUT   = 2000;
	localparam int MEM_WORDS = 256;

	logic                  clock;
	logic                  arst_n;
	logic                  load_req;
	logic [XLEN-1:0]       load_addr;
	logic [XLEN-1:0]       load_data;
	logic                  load_ack;
	logic                  run_req;
	logic                  run_ack;
	logic                  reg_req;
	logic [REG_ADDR_W-1:0] reg_addr;
	logic                  reg_ack;
	logic [XLEN-1:0]       reg_data;

	int    pass_count;
	int    fail_count;
	int    test_errs;
	string test_name;

	clock_gen clk_gen (.clock(clock), .arst_n(arst_n));

	mips_core #(.MEM_WORDS(MEM_WORDS)) UUT (
		.clock(clock), .arst_n(arst_n),
		.load_req(load_req), .load_addr(load_addr), .load_data(load_data), .load_ack(load_ack),
		.run_req(run_req), .run_ack(run_ack),
		.reg_req(reg_req), .reg_addr(reg_addr), .reg_ack(reg_ack), .reg_data(reg_data)
	);

	function automatic logic level_of(input int which);
		case (which)
			0: return load_ack;
			1: return run_ack;
			2: return reg_ack;
			default: return arst_n;
		endcase
	endfunction

	// Polled on the falling edge, DUT outputs are settled there
	task automatic await_level(input int which, input logic level, input string what);
		int cycles;
		cycles = 0;
		while (level_of(which) !== level && cycles < TIMEOUT) begin
			@(negedge clock);
			cycles++;
		end
		if (level_of(which) !== level) begin
			$display("Timeout in test %s: %s did not go to %0b within %0d cycles",
				test_name, what, level, TIMEOUT);
			$display("*** FAILED ***");
			$finish;
		end
	endtask

	task automatic idle_gap();
		repeat ($urandom % 4) @(negedge clock);
	endtask

	task automatic load_word(input logic [XLEN-1:0] addr, input logic [XLEN-1:0] word);
		load_addr = addr;
		load_data = word;
		load_req  = 1'b1;
		await_level(0, 1'b1, "load_ack");
		idle_gap();
		load_req = 1'b0;
		await_level(0, 1'b0, "load_ack");
	endtask

	task automatic run_program();
		run_req = 1'b1;
		await_level(1, 1'b1, "run_ack"); // BREAK reached writeback
		idle_gap();
		run_req = 1'b0;
		await_level(1, 1'b0, "run_ack");
	endtask

	task automatic read_reg(input logic [REG_ADDR_W-1:0] r, output logic [XLEN-1:0] value);
		reg_addr = r;
		reg_req  = 1'b1;
		await_level(2, 1'b1, "reg_ack");
		value = reg_data;
		idle_gap();
		reg_req = 1'b0;
		await_level(2, 1'b0, "reg_ack");
	endtask

	task automatic check_reg(input int r, input logic [XLEN-1:0] expected);
		logic [XLEN-1:0] actual;
		read_reg(r[REG_ADDR_W-1:0], actual);
		if (actual !== expected) begin
			$display("** Error %s: r%0d expected %08h actual %08h", test_name, r,
				expected, actual);
			test_errs++;
		end
	endtask

	task automatic finish_test();
		if (test_errs == 0) begin
			pass_count++;
			$display("test %-12s ok", test_name);
		end else begin
			fail_count++;
			$display("test %-12s failed with %0d errors", test_name, test_errs);
		end
		test_errs = 0;
	endtask

	task automatic run_file();
		int              fd;
		int              n;
		int              r;
		string           line;
		string           cmd;
		logic [XLEN-1:0] offset;
		logic [XLEN-1:0] value;
		fd = $fopen("sim/mips_tests.txt", "r");
		if (fd == 0) begin
			$display("Could not open sim/mips_tests.txt");
			fail_count++;
			return;
		end
		test_name = "";
		while ($fgets(line, fd) > 0) begin
			n = $sscanf(line, "%s", cmd);
			if (n >= 1 && cmd.getc(0) != "#") begin
				if (cmd == "test") begin
					if (test_name != "")
						finish_test();
					n = $sscanf(line, "%s %s", cmd, test_name);
				end else if (cmd == "load") begin
					n = $sscanf(line, "%s %h %h", cmd, offset, value);
					load_word(TEXT_BASE + offset, value); // Offsets count from TEXT_BASE
				end else if (cmd == "run") begin
					run_program();
				end else if (cmd == "check") begin
					n = $sscanf(line, "%s %d %h", cmd, r, value);
					check_reg(r, value);
				end else begin
					$display("Unknown command in tests file: %s", cmd);
					test_errs++;
				end
			end
		end
		if (test_name != "")
			finish_test();
		$fclose(fd);
	endtask

	initial begin
		load_req   = 1'b0;
		load_addr  = '0;
		load_data  = '0;
		run_req    = 1'b0;
		reg_req    = 1'b0;
		reg_addr   = '0;
		pass_count = 0;
		fail_count = 0;
		test_errs  = 0;
		test_name  = "reset_state";
		void'($urandom(92297));
		await_level(3, 1'b1, "arst_n");
		@(negedge clock);
		if ({load_ack, run_ack, reg_ack} !== 3'b000) begin
			$display("** Error %s: acks expected 000 actual %b", test_name,
				{load_ack, run_ack, reg_ack});
			test_errs++;
		end
		for (int r = 0; r < 2**REG_ADDR_W; r++)
			check_reg(r, '0);
		finish_test();
		run_file();
		if (UUT.u_props.failures != 0) begin
			$display("Handshake assertions failed %0d times", UUT.u_props.failures);
			fail_count++;
		end
		$display("Tests: %0d passed, %0d failed", pass_count, fail_count);
		if (fail_count == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

// ==== sim/mips_core_properties.sv ====
`timescale 1ns/1ps

module mips_core_properties (
	input logic clock,
	input logic arst_n,
	input logic load_req,
	input logic load_ack,
	input logic run_req,
	input logic run_ack,
	input logic reg_req,
	input logic reg_ack
);

	int failures = 0;

	// An ack only answers a request seen at the edge before
	load_ack_has_req: assert property (@(posedge clock) disable iff (!arst_n)
		$rose(load_ack) |-> $past(load_req))
		else begin
			$error("load_ack rose without load_req");
			failures++;
		end

	run_ack_has_req: assert property (@(posedge clock) disable iff (!arst_n)
		$rose(run_ack) |-> $past(run_req))
		else begin
			$error("run_ack rose without run_req");
			failures++;
		end

	reg_ack_has_req: assert property (@(posedge clock) disable iff (!arst_n)
		$rose(reg_ack) |-> $past(reg_req))
		else begin
			$error("reg_ack rose without reg_req");
			failures++;
		end

	run_ack_held: assert property (@(posedge clock) disable iff (!arst_n)
		run_ack && run_req |=> run_ack)
		else begin
			$error("run_ack fell while run_req was still high");
			failures++;
		end

	acks_low_after_reset: assert property (@(posedge clock)
		$rose(arst_n) |-> !load_ack && !run_ack && !reg_ack)
		else begin
			$error("ack high right after reset");
			failures++;
		end

endmodule

bind mips_core mips_core_properties u_props (
	.clock(clock), .arst_n(arst_n),
	.load_req(load_req), .load_ack(load_ack),
	.run_req(run_req), .run_ack(run_ack),
	.reg_req(reg_req), .reg_ack(reg_ack)
);

// ==== sim/clock_gen.sv ====
`timescale 1ns/1ps

module clock_gen #(
	parameter real PERIOD       = 8.0,
	parameter int  RESET_CYCLES = 5
) (
	output logic clock,
	output logic arst_n
);

	initial begin
		clock = 1'b0;
		forever #(PERIOD / 2.0) clock = ~clock;
	end

	// Release on a falling edge, away from the sampling edge
	initial begin
		arst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clock);
		@(negedge clock);
		arst_n = 1'b1;
	end

endmodule

// ==== design/mips_core.sv ====
`timescale 1ns/1ps

module mips_core #(
	parameter int MEM_WORDS = 256
) (
	input  logic                             clock,
	input  logic                             arst_n,
	input  logic                             load_req,
	input  logic [mips_pkg::XLEN-1:0]        load_addr,
	input  logic [mips_pkg::XLEN-1:0]        load_data,
	output logic                             load_ack,
	input  logic                             run_req,
	output logic                             run_ack,
	input  logic                             reg_req,
	input  logic [mips_pkg::REG_ADDR_W-1:0]  reg_addr,
	output logic                             reg_ack,
	output logic [mips_pkg::XLEN-1:0]        reg_data
);
	import mips_pkg::*;

	localparam int AW = $clog2(MEM_WORDS);

	insn_t                 insn;
	pc_sel_t               pc_sel;
	logic                  pc_advance;
	logic                  pc_restart;
	logic [XLEN-1:0]       pc;
	logic [XLEN-1:0]       rs_data;
	logic [XLEN-1:0]       rt_data;
	logic [XLEN-1:0]       alu_result;
	logic                  branch_taken;
	logic [AW-1:0]         mem_addr;
	logic [XLEN-1:0]       mem_wdata;
	logic [XLEN-1:0]       mem_rdata;
	logic                  mem_we;
	logic [REG_ADDR_W-1:0] rf_waddr;
	logic [XLEN-1:0]       rf_wdata;
	logic                  rf_we;

	stage_sequencer #(.MEM_WORDS(MEM_WORDS)) u_sequencer (
		.clock(clock), .arst_n(arst_n),
		.load_req(load_req), .load_addr(load_addr), .load_data(load_data), .load_ack(load_ack),
		.run_req(run_req), .run_ack(run_ack),
		.reg_req(reg_req), .reg_ack(reg_ack),
		.pc(pc), .alu_result(alu_result), .branch_taken(branch_taken),
		.rt_data(rt_data), .mem_rdata(mem_rdata), .insn(insn),
		.pc_advance(pc_advance), .pc_restart(pc_restart), .pc_sel(pc_sel),
		.mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_we(mem_we),
		.rf_waddr(rf_waddr), .rf_wdata(rf_wdata), .rf_we(rf_we)
	);

	pc_counter u_pc (
		.clock(clock), .arst_n(arst_n),
		.pc_advance(pc_advance), .pc_restart(pc_restart), .pc_sel(pc_sel),
		.insn(insn), .pc(pc)
	);

	register_file u_regs (
		.clock(clock), .arst_n(arst_n),
		.rs_addr(insn.r.rs), .rt_addr(insn.r.rt), .dbg_addr(reg_addr),
		.rs_data(rs_data), .rt_data(rt_data), .dbg_data(reg_data),
		.waddr(rf_waddr), .wdata(rf_wdata), .we(rf_we)
	);

	alu u_alu (
		.insn(insn), .rs_data(rs_data), .rt_data(rt_data),
		.result(alu_result), .branch_taken(branch_taken)
	);

	unified_memory #(.MEM_WORDS(MEM_WORDS)) u_mem (
		.clock(clock), .addr(mem_addr), .wdata(mem_wdata), .we(mem_we), .rdata(mem_rdata)
	);

endmodule

// ==== design/stage_sequencer.sv ====
`timescale 1ns/1ps

module stage_sequencer #(
	parameter int MEM_WORDS = 256
) (
	input  logic                             clock,
	input  logic                             arst_n,
	input  logic                             load_req,
	input  logic [mips_pkg::XLEN-1:0]        load_addr,
	input  logic [mips_pkg::XLEN-1:0]        load_data,
	output logic                             load_ack,
	input  logic                             run_req,
	output logic                             run_ack,
	input  logic                             reg_req,
	output logic                             reg_ack,
	input  logic [mips_pkg::XLEN-1:0]        pc,
	input  logic [mips_pkg::XLEN-1:0]        alu_result,
	input  logic                             branch_taken,
	input  logic [mips_pkg::XLEN-1:0]        rt_data,
	input  logic [mips_pkg::XLEN-1:0]        mem_rdata,
	output mips_pkg::insn_t                  insn,
	output logic                             pc_advance,
	output logic                             pc_restart,
	output mips_pkg::pc_sel_t                pc_sel,
	output logic [$clog2(MEM_WORDS)-1:0]     mem_addr,
	output logic [mips_pkg::XLEN-1:0]        mem_wdata,
	output logic                             mem_we,
	output logic [mips_pkg::REG_ADDR_W-1:0]  rf_waddr,
	output logic [mips_pkg::XLEN-1:0]        rf_wdata,
	output logic                             rf_we
);
	import mips_pkg::*;

	localparam int AW = $clog2(MEM_WORDS);

	stage_t          state;
	stage_t          next_state;
	logic [XLEN-1:0] result_q;
	logic            taken_q;
	logic            idle_free;
	logic            load_go;
	logic            reg_go;
	logic            run_go;
	logic            is_lw;
	logic            is_sw;
	logic            is_break;
	logic            writes_reg;

	// One host request at a time, load first, then register read, then run
	assign idle_free = (state == IDLE) && !load_ack && !reg_ack;
	assign load_go   = idle_free && load_req;
	assign reg_go    = idle_free && !load_req && reg_req;
	assign run_go    = idle_free && !load_req && !reg_req && run_req;

	assign is_lw    = (insn.i.opcode == OP_LW);
	assign is_sw    = (insn.i.opcode == OP_SW);
	assign is_break = (insn.r.opcode == OP_RTYPE) && (insn.r.funct == FN_BREAK);

	always_comb begin
		case (insn.r.opcode)
			OP_RTYPE: writes_reg = (insn.r.funct == FN_ADDU) || (insn.r.funct == FN_SUBU) ||
				(insn.r.funct == FN_AND) || (insn.r.funct == FN_OR) || (insn.r.funct == FN_SLT);
			OP_ADDIU, OP_ORI, OP_LUI, OP_LW: writes_reg = 1'b1;
			default: writes_reg = 1'b0; // Unknown opcodes fall through as no-ops
		endcase
	end

	always_comb begin
		case (state)
			IDLE:      next_state = run_go ? FETCH : IDLE;
			FETCH:     next_state = DECODE;
			DECODE:    next_state = EXECUTE;
			EXECUTE:   next_state = (is_lw || is_sw) ? MEMORY : WRITEBACK;
			MEMORY:    next_state = WRITEBACK;
			WRITEBACK: next_state = is_break ? DONE : FETCH;
			DONE:      next_state = run_req ? DONE : IDLE;
			default:   next_state = IDLE;
		endcase
	end

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			state    <= IDLE;
			load_ack <= 1'b0;
			reg_ack  <= 1'b0;
		end else begin
			state    <= next_state;
			load_ack <= load_go || (load_ack && load_req);
			reg_ack  <= reg_go || (reg_ack && reg_req);
		end
	end

	always_ff @(posedge clock) begin
		if (state == DECODE)
			insn <= mem_rdata; // Word fetched in the previous cycle
		if (state == EXECUTE) begin
			result_q <= alu_result;
			taken_q  <= branch_taken;
		end
	end

	assign run_ack    = (state == DONE);
	assign pc_restart = run_go;
	assign pc_advance = (state == WRITEBACK);
	assign pc_sel     = (insn.j.opcode == OP_J) ? PC_JUMP : (taken_q ? PC_BRANCH : PC_SEQ);

	always_comb begin
		case (state)
			IDLE:    mem_addr = load_addr[AW+1:2];
			MEMORY:  mem_addr = result_q[AW+1:2];
			default: mem_addr = pc[AW+1:2];
		endcase
	end

	assign mem_wdata = (state == MEMORY) ? rt_data : load_data;
	assign mem_we    = load_go || ((state == MEMORY) && is_sw);

	assign rf_waddr = (insn.r.opcode == OP_RTYPE) ? insn.r.rd : insn.i.rt;
	assign rf_wdata = is_lw ? mem_rdata : result_q;
	assign rf_we    = (state == WRITEBACK) && writes_reg;

endmodule

// ==== design/unified_memory.sv ====
`timescale 1ns/1ps

module unified_memory #(
	parameter int MEM_WORDS = 256
) (
	input  logic                         clock,
	input  logic [$clog2(MEM_WORDS)-1:0] addr,
	input  logic [mips_pkg::XLEN-1:0]    wdata,
	input  logic                         we,
	output logic [mips_pkg::XLEN-1:0]    rdata
);
	import mips_pkg::*;

	logic [XLEN-1:0] mem [MEM_WORDS]; // Program and data share this array

	always_ff @(posedge clock) begin
		if (we)
			mem[addr] <= wdata;
		rdata <= mem[addr]; // Old word on a same-cycle write
	end

endmodule

// ==== design/register_file.sv ====
`timescale 1ns/1ps

module register_file (
	input  logic                            clock,
	input  logic                            arst_n,
	input  logic [mips_pkg::REG_ADDR_W-1:0] rs_addr,
	input  logic [mips_pkg::REG_ADDR_W-1:0] rt_addr,
	input  logic [mips_pkg::REG_ADDR_W-1:0] dbg_addr,
	output logic [mips_pkg::XLEN-1:0]       rs_data,
	output logic [mips_pkg::XLEN-1:0]       rt_data,
	output logic [mips_pkg::XLEN-1:0]       dbg_data,
	input  logic [mips_pkg::REG_ADDR_W-1:0] waddr,
	input  logic [mips_pkg::XLEN-1:0]       wdata,
	input  logic                            we
);
	import mips_pkg::*;

	localparam int NREGS = 2**REG_ADDR_W;

	logic [XLEN-1:0] regs [1:NREGS-1]; // No storage behind $zero

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 1; i < NREGS; i++)
				regs[i] <= '0;
		end else if (we && (waddr != '0)) begin
			regs[waddr] <= wdata;
		end
	end

	// Combinational reads
	assign rs_data  = (rs_addr == '0) ? '0 : regs[rs_addr];
	assign rt_data  = (rt_addr == '0) ? '0 : regs[rt_addr];
	assign dbg_data = (dbg_addr == '0) ? '0 : regs[dbg_addr];

endmodule

// ==== design/pc_counter.sv ====
`timescale 1ns/1ps

module pc_counter (
	input  logic                      clock,
	input  logic                      arst_n,
	input  logic                      pc_advance,
	input  logic                      pc_restart,
	input  mips_pkg::pc_sel_t         pc_sel,
	input  mips_pkg::insn_t           insn,
	output logic [mips_pkg::XLEN-1:0] pc
);
	import mips_pkg::*;

	logic [XLEN-1:0] pc_plus4;
	logic [XLEN-1:0] branch_target;
	logic [XLEN-1:0] jump_target;
	logic [XLEN-1:0] pc_next;

	assign pc_plus4 = pc + XLEN'(4);

	// Word offset relative to the following instruction
	assign branch_target = pc_plus4 + {{(XLEN-18){insn.i.imm16[15]}}, insn.i.imm16, 2'b00};

	// Stays inside the current 256 MB region
	assign jump_target = {pc_plus4[XLEN-1:28], insn.j.index26, 2'b00};

	always_comb begin
		case (pc_sel)
			PC_BRANCH: pc_next = branch_target;
			PC_JUMP:   pc_next = jump_target;
			default:   pc_next = pc_plus4;
		endcase
	end

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n)
			pc <= TEXT_BASE;
		else if (pc_restart)
			pc <= TEXT_BASE; // Every run starts over
		else if (pc_advance)
			pc <= pc_next;
	end

endmodule

// ==== design/alu.sv ====
`timescale 1ns/1ps

module alu (
	input  mips_pkg::insn_t           insn,
	input  logic [mips_pkg::XLEN-1:0] rs_data,
	input  logic [mips_pkg::XLEN-1:0] rt_data,
	output logic [mips_pkg::XLEN-1:0] result,
	output logic                      branch_taken
);
	import mips_pkg::*;

	logic [XLEN-1:0] imm_sext;
	logic [XLEN-1:0] imm_zext;
	logic [XLEN-1:0] diff;
	logic            less;

	assign imm_sext = {{(XLEN-16){insn.i.imm16[15]}}, insn.i.imm16};
	assign imm_zext = {{(XLEN-16){1'b0}}, insn.i.imm16};

	assign diff = rs_data - rt_data;
	assign less = $signed(rs_data) < $signed(rt_data);

	always_comb begin
		case (insn.r.opcode)
			OP_RTYPE: begin
				case (insn.r.funct)
					FN_ADDU: result = rs_data + rt_data;
					FN_SUBU: result = diff;
					FN_AND:  result = rs_data & rt_data;
					FN_OR:   result = rs_data | rt_data;
					FN_SLT:  result = {{(XLEN-1){1'b0}}, less};
					default: result = '0;
				endcase
			end
			OP_ADDIU, OP_LW, OP_SW: result = rs_data + imm_sext; // Also the load/store address
			OP_ORI: result = rs_data | imm_zext;
			OP_LUI: result = {insn.i.imm16, {(XLEN-16){1'b0}}};
			default: result = '0;
		endcase
	end

	// Branch compare on the subtractor output
	always_comb begin
		case (insn.i.opcode)
			OP_BEQ:  branch_taken = (diff == '0);
			OP_BNE:  branch_taken = (diff != '0);
			default: branch_taken = 1'b0;
		endcase
	end

endmodule

// ==== common/mips_pkg.sv ====
package mips_pkg;

	localparam int XLEN       = 32;
	localparam int REG_ADDR_W = 5;

	localparam logic [XLEN-1:0] TEXT_BASE = 32'h8002_0000;

	// Primary opcodes
	localparam logic [5:0] OP_RTYPE = 6'b000000;
	localparam logic [5:0] OP_J     = 6'b000010;
	localparam logic [5:0] OP_BEQ   = 6'b000100;
	localparam logic [5:0] OP_BNE   = 6'b000101;
	localparam logic [5:0] OP_ADDIU = 6'b001001;
	localparam logic [5:0] OP_ORI   = 6'b001101;
	localparam logic [5:0] OP_LUI   = 6'b001111;
	localparam logic [5:0] OP_LW    = 6'b100011;
	localparam logic [5:0] OP_SW    = 6'b101011;

	// R-type function field
	localparam logic [5:0] FN_BREAK = 6'b001101;
	localparam logic [5:0] FN_ADDU  = 6'b100001;
	localparam logic [5:0] FN_SUBU  = 6'b100011;
	localparam logic [5:0] FN_AND   = 6'b100100;
	localparam logic [5:0] FN_OR    = 6'b100101;
	localparam logic [5:0] FN_SLT   = 6'b101010;

	typedef struct packed {
		logic [5:0]            opcode;
		logic [REG_ADDR_W-1:0] rs;
		logic [REG_ADDR_W-1:0] rt;
		logic [REG_ADDR_W-1:0] rd;
		logic [4:0]            shamt;
		logic [5:0]            funct;
	} r_insn_t;

	typedef struct packed {
		logic [5:0]            opcode;
		logic [REG_ADDR_W-1:0] rs;
		logic [REG_ADDR_W-1:0] rt;
		logic [15:0]           imm16;
	} i_insn_t;

	typedef struct packed {
		logic [5:0]  opcode;
		logic [25:0] index26;
	} j_insn_t;

	// Same 32-bit word, three field layouts
	typedef union packed {
		r_insn_t r;
		i_insn_t i;
		j_insn_t j;
	} insn_t;

	typedef enum logic [1:0] {
		PC_SEQ,
		PC_BRANCH,
		PC_JUMP
	} pc_sel_t;

	typedef enum logic [2:0] {
		IDLE,
		FETCH,
		DECODE,
		EXECUTE,
		MEMORY,
		WRITEBACK,
		DONE
	} stage_t;

endpackage
